// File: float_unit.f
hw/float_pkg.sv
hw/float_decode.sv
hw/float_execute.sv
hw/float_result_stage.sv
hw/float_unit.sv
tb/float_unit_sva.sv
tb/float_unit_tb.sv

// File: hw/float_decode.sv
`timescale 1ns/100ps

module float_decode (
    input  float_pkg::float_command_t command,
    output float_pkg::float_op_t      op,
    output logic                      produce
);
    import float_pkg::*;

    fp_instr_t instr;

    assign instr = command.instruction;

    always_comb begin
        produce = 1'b0;
        op.op   = op_fmv_x_w;
        op.a    = command.rs1_value;
        op.b    = command.rs2_value;
        op.addr = command.dest_reg_addr;

        if (instr.r.opcode == opcode_op_fp) begin
            case (instr.r.funct7)
                funct7_fmv_x_w: begin
                    if (instr.r.funct3 == funct3_fmv_x_w && instr.r.rs2 == 5'd0) begin
                        op.op   = op_fmv_x_w;
                        produce = 1'b1;
                    end
                end
                funct7_fcvt_w_s: begin
                    // funct3 is the rounding mode, ignored since we always truncate
                    case (instr.r.rs2)
                        rs2_sel_w: begin
                            op.op   = op_fcvt_w;
                            produce = 1'b1;
                        end
                        rs2_sel_wu: begin
                            op.op   = op_fcvt_wu;
                            produce = 1'b1;
                        end
                        default: ;
                    endcase
                end
                funct7_fcmp_s: begin
                    case (instr.r.funct3)
                        funct3_feq: begin
                            op.op   = op_feq;
                            produce = 1'b1;
                        end
                        funct3_flt: begin
                            op.op   = op_flt;
                            produce = 1'b1;
                        end
                        funct3_fle: begin
                            op.op   = op_fle;
                            produce = 1'b1;
                        end
                        default: ;
                    endcase
                end
                default: ; // float destinations and illegal encodings are dropped
            endcase
        end
    end

endmodule

// File: hw/float_execute.sv
`timescale 1ns/100ps

module float_execute (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     command_valid,
    output logic                     command_ready,
    input  float_pkg::float_op_t     op,
    input  logic                     produce,
    output logic                     exe_valid,
    input  logic                     exe_ready,
    output float_pkg::float_result_t exe_result
);
    import float_pkg::*;

    float_op_t       op_q;
    logic            valid_q;
    logic [xlen-1:0] value;
    logic            nan_any;
    logic            both_zero;
    logic            eq;
    logic            lt;

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    // integer part of |x| for biased exponents 127 to 158
    function automatic logic [31:0] int_magnitude(input logic [31:0] x);
        logic [7:0]  e;
        logic [31:0] sig;
        e   = x[30:23] - 8'd127;
        sig = {8'd0, 1'b1, x[22:0]};
        if (e >= 8'd23) begin
            return sig << (e - 8'd23);
        end
        return sig >> (8'd23 - e);
    endfunction

    function automatic logic [31:0] fcvt_w(input logic [31:0] x);
        logic [31:0] mag;
        mag = int_magnitude(x);
        if (is_nan(x)) begin
            return 32'h7fff_ffff;
        end
        if (x[30:23] < 8'd127) begin
            return 32'd0; // |x| < 1
        end
        if (x[30:23] >= 8'd158) begin
            // -2^31 itself lands here too and is exact
            return x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        return x[31] ? -mag : mag;
    endfunction

    function automatic logic [31:0] fcvt_wu(input logic [31:0] x);
        if (is_nan(x)) begin
            return 32'hffff_ffff;
        end
        if (x[31] || x[30:23] < 8'd127) begin
            return 32'd0;
        end
        if (x[30:23] >= 8'd159) begin
            return 32'hffff_ffff; // |x| >= 2^32
        end
        return int_magnitude(x);
    endfunction

    assign command_ready = !valid_q || exe_ready;
    assign exe_valid     = valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (command_ready) begin
            valid_q <= command_valid && produce; // dropped commands leave it empty
        end
    end

    always_ff @(posedge clk) begin
        if (command_ready && command_valid && produce) begin
            op_q <= op;
        end
    end

    // +0 and -0 compare equal
    always_comb begin
        nan_any   = is_nan(op_q.a) || is_nan(op_q.b);
        both_zero = (op_q.a[30:0] == 31'd0) && (op_q.b[30:0] == 31'd0);
        eq        = (op_q.a == op_q.b) || both_zero;
        if (op_q.a[31] != op_q.b[31]) begin
            lt = op_q.a[31] && !both_zero;
        end else if (!op_q.a[31]) begin
            lt = op_q.a[30:0] < op_q.b[30:0];
        end else begin
            lt = op_q.a[30:0] > op_q.b[30:0]; // with both negative the larger magnitude is smaller
        end
    end

    always_comb begin
        case (op_q.op)
            op_fcvt_w:  value = fcvt_w(op_q.a);
            op_fcvt_wu: value = fcvt_wu(op_q.a);
            op_feq:     value = {31'd0, !nan_any && eq};
            op_flt:     value = {31'd0, !nan_any && lt};
            op_fle:     value = {31'd0, !nan_any && (lt || eq)};
            default:    value = op_q.a; // FMV.X.W passes the raw bits
        endcase
    end

    assign exe_result.addr  = op_q.addr;
    assign exe_result.value = value;

endmodule

// File: hw/float_pkg.sv
package float_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    localparam logic [6:0] opcode_op_fp = 7'b1010011;

    // funct7 values of the OP-FP instructions with an integer destination
    localparam logic [6:0] funct7_fmv_x_w  = 7'b1110000;
    localparam logic [6:0] funct7_fcvt_w_s = 7'b1100000; // rs2 tells the W and WU forms apart
    localparam logic [6:0] funct7_fcmp_s   = 7'b1010000;

    localparam logic [2:0] funct3_fmv_x_w = 3'b000; // 3'b001 in the same slot is FCLASS
    localparam logic [2:0] funct3_feq     = 3'b010;
    localparam logic [2:0] funct3_flt     = 3'b001;
    localparam logic [2:0] funct3_fle     = 3'b000;

    localparam logic [4:0] rs2_sel_w  = 5'b00000;
    localparam logic [4:0] rs2_sel_wu = 5'b00001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } fp_rtype_t;

    // issue side writes raw, decode looks at the fields
    typedef union packed {
        logic [31:0] raw;
        fp_rtype_t   r;
    } fp_instr_t;

    typedef enum logic [2:0] {
        op_fmv_x_w,
        op_fcvt_w,
        op_fcvt_wu,
        op_feq,
        op_flt,
        op_fle
    } fp_op_e;

    typedef struct packed {
        fp_instr_t                 instruction;
        logic [xlen-1:0]           rs1_value;
        logic [xlen-1:0]           rs2_value;
        logic [reg_addr_width-1:0] dest_reg_addr; // renamed destination while rd stays raw
    } float_command_t;

    typedef struct packed {
        fp_op_e                    op;
        logic [xlen-1:0]           a;
        logic [xlen-1:0]           b;
        logic [reg_addr_width-1:0] addr;
    } float_op_t;

    typedef struct packed {
        logic [reg_addr_width-1:0] addr;
        logic [xlen-1:0]           value;
    } float_result_t;

endpackage

// File: hw/float_result_stage.sv
`timescale 1ns/100ps

module float_result_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     exe_valid,
    output logic                     exe_ready,
    input  float_pkg::float_result_t exe_result,
    output logic                     result_valid,
    input  logic                     result_ready,
    output float_pkg::float_result_t result
);
    import float_pkg::*;

    float_result_t out_q;
    float_result_t skid_q;
    logic          out_valid_q;
    logic          skid_valid_q;
    logic          in_xfer;
    logic          out_free;

    // straight from a flop, no path from result_ready
    assign exe_ready = !skid_valid_q;

    assign in_xfer  = exe_valid && exe_ready;
    assign out_free = !out_valid_q || result_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            // skid entry drains first, no input can arrive while it is full
            out_valid_q  <= skid_valid_q || in_xfer;
            skid_valid_q <= 1'b0;
        end else if (in_xfer) begin
            skid_valid_q <= 1'b1; // output stalled, park the new one
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_q <= skid_valid_q ? skid_q : exe_result;
        end
        if (!out_free && in_xfer) begin
            skid_q <= exe_result;
        end
    end

    assign result_valid = out_valid_q;
    assign result       = out_q;

endmodule

// File: hw/float_unit.sv
`timescale 1ns/100ps

module float_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      command_valid,
    output logic                      command_ready,
    input  float_pkg::float_command_t command,
    output logic                      result_valid,
    input  logic                      result_ready,
    output float_pkg::float_result_t  result
);
    import float_pkg::*;

    float_op_t     op;
    logic          produce;
    logic          exe_valid;
    logic          exe_ready;
    float_result_t exe_result;

    float_decode decode_inst (
        .command (command),
        .op      (op),
        .produce (produce)
    );

    float_execute execute_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .command_valid (command_valid),
        .command_ready (command_ready),
        .op            (op),
        .produce       (produce),
        .exe_valid     (exe_valid),
        .exe_ready     (exe_ready),
        .exe_result    (exe_result)
    );

    // registered output toward the core
    float_result_stage result_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .exe_valid    (exe_valid),
        .exe_ready    (exe_ready),
        .exe_result   (exe_result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the float unit testbench with Verilator and runs it
# exit status is nonzero when the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module float_unit_tb \
    -f float_unit.f \
    -o float_unit_sim \
    && ./obj_dir/float_unit_sim \
    || { echo "float unit simulation did not complete cleanly"; exit 1; }

// File: tb/float_unit_sva.sv
`timescale 1ns/100ps

module float_unit_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     command_valid,
    input logic                     command_ready,
    input logic                     produce,
    input logic                     result_valid,
    input logic                     result_ready,
    input float_pkg::float_result_t result
);
    logic take; // producing command accepted at this edge

    assign take = command_valid && command_ready && produce;

    property result_held;
        @(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result);
    endproperty

    property quiet_after_reset;
        @(posedge clk) !rst_n |=> !result_valid;
    endproperty

    // accepted at edge N with the consumer ready, offered at edge N+2
    property two_cycle_latency;
        @(posedge clk) disable iff (!rst_n)
        $past(take && result_ready && rst_n, 2) && $past(result_ready && rst_n) |-> result_valid;
    endproperty

    assert property (result_held) else $error("result payload moved while stalled");
    assert property (quiet_after_reset) else $error("result_valid high right after reset");
    assert property (two_cycle_latency) else $error("result late after command transfer");

endmodule

bind float_unit float_unit_sva sva_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .command_valid (command_valid),
    .command_ready (command_ready),
    .produce       (produce),
    .result_valid  (result_valid),
    .result_ready  (result_ready),
    .result        (result)
);

// File: tb/float_unit_tb.sv
`timescale 1ns/100ps

module float_unit_tb;
    import float_pkg::*;

    localparam int         max_cycles = 5000;
    localparam logic [6:0] op_fp      = 7'h53;
    localparam logic [6:0] f7_fmv     = 7'h70;
    localparam logic [6:0] f7_cvt     = 7'h60;
    localparam logic [6:0] f7_cmp     = 7'h50;

    logic           clk = 1'b0;
    logic           rst_n = 1'b0;
    logic           command_valid = 1'b0;
    logic           command_ready;
    float_command_t command = '0;
    logic           result_valid;
    logic           result_ready = 1'b1;
    float_result_t  result;

    float_result_t  exp_q[$];
    int             cycle;
    logic           ready_random;
    logic           ready_hold;
    logic [1023:0]  ready_pattern;

    float_unit DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .command_valid (command_valid),
        .command_ready (command_ready),
        .command       (command),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result        (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout after %0d cycles with %0d results outstanding", cycle, exp_q.size());
            $display("TEST FAIL");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    always @(negedge clk) begin
        if (ready_random) begin
            result_ready = ready_pattern[cycle[9:0]];
        end else begin
            result_ready = ready_hold;
        end
    end

    task automatic compare_result(input float_result_t got, input float_result_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: result addr %0d value %h, expected addr %0d value %h",
                     $time, got.addr, got.value, exp.addr, exp.value);
            $display("TEST FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "handshake flag mismatch");
        end
    endtask

    // a result transfers when valid and ready are high at a rising edge
    always @(posedge clk) begin
        if (rst_n && result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                $display("result for register %0d arrived with nothing expected", result.addr);
                $display("TEST FAIL");
                $fatal(1, "unexpected result");
            end else begin
                compare_result(result, exp_q.pop_front());
            end
        end
    end

    function automatic logic nan_bits(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    // maps floats onto unsigned keys in numeric order, both zeros share one key
    function automatic logic [31:0] order_key(input logic [31:0] x);
        if (x[30:0] == 31'd0) begin
            return 32'h8000_0000;
        end
        return x[31] ? ~x : (x | 32'h8000_0000);
    endfunction

    function automatic logic [31:0] model_fcvt(input logic [31:0] x, input logic to_unsigned);
        longint mant;
        longint mag;
        longint val;
        int     e;
        if (nan_bits(x)) begin
            return to_unsigned ? 32'hffff_ffff : 32'h7fff_ffff;
        end
        mant = {40'd0, 1'b1, x[22:0]};
        e    = int'(x[30:23]) - 150; // value is mant * 2^e
        if (x[30:23] == 8'd0) begin
            mag = 0;
        end else if (e > 20) begin
            mag = 64'sd1 << 44; // inf and anything else far out of range
        end else if (e >= 0) begin
            mag = mant << e;
        end else begin
            mag = mant >> (-e);
        end
        val = x[31] ? -mag : mag;
        if (to_unsigned) begin
            if (val < 0) begin
                return 32'd0;
            end
            return (val > 64'sh0_ffff_ffff) ? 32'hffff_ffff : val[31:0];
        end
        if (val > 64'sd2147483647) begin
            return 32'h7fff_ffff;
        end
        return (val < -64'sd2147483648) ? 32'h8000_0000 : val[31:0];
    endfunction

    // expected outcome of one command from its instruction encoding
    function automatic void model_command(input float_command_t c, output logic produces,
                                          output float_result_t exp);
        logic [31:0] w;
        logic        unordered;
        logic [31:0] ka;
        logic [31:0] kb;
        w         = c.instruction.raw;
        unordered = nan_bits(c.rs1_value) || nan_bits(c.rs2_value);
        ka        = order_key(c.rs1_value);
        kb        = order_key(c.rs2_value);
        produces  = 1'b0;
        exp.addr  = c.dest_reg_addr;
        exp.value = 32'd0;
        if (w[6:0] == op_fp && w[31:25] == f7_fmv && w[14:12] == 3'd0 && w[24:20] == 5'd0) begin
            produces  = 1'b1;
            exp.value = c.rs1_value;
        end else if (w[6:0] == op_fp && w[31:25] == f7_cvt && w[24:21] == 4'd0) begin
            produces  = 1'b1;
            exp.value = model_fcvt(c.rs1_value, w[20]);
        end else if (w[6:0] == op_fp && w[31:25] == f7_cmp && w[14:12] != 3'd3) begin
            produces = w[14:12] <= 3'd2;
            case (w[14:12])
                3'd2:    exp.value = {31'd0, !unordered && ka == kb};
                3'd1:    exp.value = {31'd0, !unordered && ka < kb};
                default: exp.value = {31'd0, !unordered && ka <= kb};
            endcase
        end
    endfunction

    function automatic fp_instr_t encode(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [2:0] f3, input logic [6:0] opcode);
        fp_instr_t i;
        i.raw = {f7, rs2, 5'd3, f3, 5'd7, opcode};
        return i;
    endfunction

    // starts and ends just after a falling edge, so back-to-back calls keep valid high
    task automatic issue(input fp_instr_t instr, input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] addr);
        float_command_t c;
        float_result_t  e;
        logic           p;
        c.instruction   = instr;
        c.rs1_value     = a;
        c.rs2_value     = b;
        c.dest_reg_addr = addr;
        model_command(c, p, e);
        command       = c;
        command_valid = 1'b1;
        while (!command_ready) @(negedge clk); // ready comes from flops only
        if (p) begin
            exp_q.push_back(e);
        end
        @(negedge clk);
        command_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic test_move();
        logic [31:0] vals[$];
        vals = '{32'h3f80_0000, 32'h7fc0_0000, 32'h8000_0000, 32'hdead_beef, 32'hff80_0001};
        foreach (vals[i]) issue(encode(f7_fmv, 5'd0, 3'd0, op_fp), vals[i], ~vals[i], 5'(i + 1));
        wait_drain();
    endtask

    task automatic test_convert();
        logic [31:0] vals[$];
        vals = '{32'h4070_0000, 32'hc070_0000, 32'h4f00_0000, 32'hcf00_0000, 32'hcf00_0001,
                 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'h8000_0000, 32'h3f00_0000,
                 32'hbf00_0000, 32'h4f80_0000, 32'h4f7f_ffff, 32'h3f80_0000};
        foreach (vals[i]) begin
            issue(encode(f7_cvt, 5'd0, 3'd1, op_fp), vals[i], 32'd0, 5'(i));
            issue(encode(f7_cvt, 5'd1, 3'(i), op_fp), vals[i], 32'd0, 5'(i + 16)); // any rm
        end
        wait_drain();
    endtask

    task automatic test_compare();
        logic [31:0] a[$];
        logic [31:0] b[$];
        a = '{32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, 32'h0000_0000, 32'h8000_0000,
              32'hbf80_0000, 32'hc000_0000, 32'hbf80_0000, 32'h7fc0_0000, 32'h3f80_0000,
              32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'h0000_0001, 32'hff80_0001};
        b = '{32'h4000_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h8000_0000, 32'h0000_0000,
              32'hc000_0000, 32'hbf80_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h7fc0_0000,
              32'h7f7f_ffff, 32'h7f80_0000, 32'h7fc0_0000, 32'h8000_0000, 32'h0000_0000};
        foreach (a[i]) begin
            issue(encode(f7_cmp, 5'd2, 3'd2, op_fp), a[i], b[i], 5'(i));
            issue(encode(f7_cmp, 5'd2, 3'd1, op_fp), a[i], b[i], 5'(i + 1));
            issue(encode(f7_cmp, 5'd2, 3'd0, op_fp), a[i], b[i], 5'(i + 2));
        end
        wait_drain();
    endtask

    // float destinations and illegal encodings between producing commands
    task automatic test_mixed();
        issue(encode(7'h00, 5'd2, 3'd0, op_fp), 32'h3f80_0000, 32'h3f80_0000, 5'd1); // fadd
        issue(encode(f7_fmv, 5'd0, 3'd0, op_fp), 32'h1234_5678, 32'd0, 5'd2);
        issue(encode(7'h78, 5'd0, 3'd0, op_fp), 32'h4000_0000, 32'd0, 5'd3); // fmv.w.x
        issue(encode(f7_fmv, 5'd0, 3'd1, op_fp), 32'h4000_0000, 32'd0, 5'd4); // fclass
        issue(encode(f7_cmp, 5'd2, 3'd1, op_fp), 32'hbf80_0000, 32'h3f80_0000, 5'd5);
        issue(encode(7'h68, 5'd0, 3'd1, op_fp), 32'd7, 32'd0, 5'd6); // fcvt.s.w
        issue(encode(f7_fmv, 5'd0, 3'd0, 7'h33), 32'hffff_ffff, 32'd0, 5'd7);
        issue(encode(f7_cmp, 5'd2, 3'd3, op_fp), 32'd0, 32'd0, 5'd8);
        issue(encode(f7_cvt, 5'd2, 3'd1, op_fp), 32'h4070_0000, 32'd0, 5'd9);
        issue(encode(f7_fmv, 5'd4, 3'd0, op_fp), 32'h4070_0000, 32'd0, 5'd10);
        issue(encode(f7_cvt, 5'd0, 3'd1, op_fp), 32'hc070_0000, 32'd0, 5'd11);
        wait_drain();
    endtask

    task automatic test_random_burst();
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        ready_random <= 1'b1;
        for (int n = 0; n < 200; n++) begin
            sel = $urandom;
            a   = $urandom;
            b   = sel[8] ? a : $urandom; // equal operands now and then
            case (sel[2:0])
                3'd0:    issue(encode(f7_fmv, 5'd0, 3'd0, op_fp), a, b, sel[15:11]);
                3'd1:    issue(encode(f7_cvt, 5'd0, sel[5:3], op_fp), a, b, sel[15:11]);
                3'd2:    issue(encode(f7_cvt, 5'd1, sel[5:3], op_fp), a, b, sel[15:11]);
                3'd3:    issue(encode(f7_cmp, 5'd2, 3'd2, op_fp), a, b, sel[15:11]);
                3'd4:    issue(encode(f7_cmp, 5'd2, 3'd1, op_fp), a, b, sel[15:11]);
                3'd5:    issue(encode(f7_cmp, 5'd2, 3'd0, op_fp), a, b, sel[15:11]);
                3'd6:    issue(encode(7'h00, 5'd2, 3'd0, op_fp), a, b, sel[15:11]);
                default: issue(encode(f7_fmv, 5'd0, 3'd0, 7'h13), a, b, sel[15:11]);
            endcase
        end
        ready_random <= 1'b0;
        wait_drain();
    endtask

    task automatic test_reset_midstream();
        ready_hold <= 1'b0;
        issue(encode(f7_fmv, 5'd0, 3'd0, op_fp), 32'h0bad_f00d, 32'd0, 5'd20);
        issue(encode(f7_cvt, 5'd0, 3'd1, op_fp), 32'h4070_0000, 32'd0, 5'd21);
        issue(encode(f7_cmp, 5'd2, 3'd0, op_fp), 32'h3f80_0000, 32'h3f80_0000, 5'd22);
        // output, skid entry and execute register all hold a result now
        check_flag(command_ready, 1'b0, "command_ready with three results held");
        rst_n = 1'b0;
        exp_q.delete(); // in-flight results are lost by the reset
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        ready_hold <= 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_flag(result_valid, 1'b0, "result_valid after reset");
            check_flag(command_ready, 1'b1, "command_ready after reset");
        end
        issue(encode(f7_fmv, 5'd0, 3'd0, op_fp), 32'h5555_aaaa, 32'd0, 5'd23);
        wait_drain();
    endtask

    initial begin
        logic [31:0] tmp;
        ready_random <= 1'b0;
        ready_hold   <= 1'b1;
        tmp = $urandom(32'he6bb_4a1a);
        for (int i = 0; i < 1024; i++) begin
            tmp = $urandom;
            ready_pattern[i] = tmp[0];
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_move();
        test_convert();
        test_compare();
        test_mixed();
        test_random_burst();
        test_reset_midstream();
        if (exp_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_q.size());
            $display("TEST FAIL");
            $fatal(1, "missing results");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
